//--- common/bwt_pkg.sv
package bwt_pkg;

	// ------------------------------------------------
	// occurrence block geometry
	// ------------------------------------------------
	localparam int BLOCK_BASES = 128;
	localparam int BLOCK_SHIFT = $clog2(BLOCK_BASES);
	localparam int L2_COUNT    = 4;  // bases A C G T
	localparam int LANE_BASES  = 32; // bases per 64-bit lane word

	// block offset j lives in lane j / LANE_BASES
	// at bits 2*(j % LANE_BASES) + 1 .. 2*(j % LANE_BASES)

	// ------------------------------------------------
	// index types
	// ------------------------------------------------
	typedef logic [63:0] bwt_pos_t;   // position or interval bound
	typedef logic [31:0] occ_cnt_t;   // base count at block start
	typedef logic [63:0] bwt_bases_t; // one lane of packed block bases
	typedef logic [31:0] dram_addr_t; // block number

endpackage

//--- common/read_pkg.sv
package read_pkg;

	localparam int READ_NUM_WIDTH = 8;
	localparam int MAX_READ_LEN   = 128;

	typedef logic [READ_NUM_WIDTH-1:0] read_num_t;
	typedef logic [1:0]                base_t;       // A=0 C=1 G=2 T=3
	typedef logic [7:0]                read_len_t;
	typedef logic [2*MAX_READ_LEN-1:0] read_bases_t; // base i at bits 2i+1..2i
	typedef logic [511:0]              load_word_t;
	typedef logic [511:0]              result_word_t;

	// ------------------------------------------------
	// load word layout
	// ------------------------------------------------
	// read words
	localparam int LW_BASES_LSB    = 0;
	localparam int LW_LEN_LSB      = 256;
	localparam int LW_MIN_INTV_LSB = 264;

	// first word of a batch
	localparam int LW_PRIMARY_LSB = 0;
	localparam int LW_L2_LSB      = 64;  // L2_0..L2_3 in consecutive 64-bit fields
	localparam int LW_CNT_T_LSB   = 320; // occurrences of T in the text

	// ------------------------------------------------
	// result word layout, unused bits zero
	// ------------------------------------------------
	localparam int RW_NUM_LSB = 0;
	localparam int RW_LEN_LSB = 8;
	localparam int RW_K_LSB   = 64;
	localparam int RW_L_LSB   = 128;

endpackage

//--- common/smem_ifs.sv
interface read_if
	import bwt_pkg::*;
	import read_pkg::*;
();
	logic        new_read;       // one-cycle pulse from the extender
	logic        new_read_valid; // next read, one cycle after new_read
	logic        batch_done;     // same slot, once every read is out
	logic        load_done;
	logic        last;           // final read of the batch
	read_num_t   read_num;
	read_bases_t bases;
	read_len_t   len;
	read_len_t   min_intv;
	bwt_pos_t    primary;
	bwt_pos_t    l2 [L2_COUNT];
	bwt_pos_t    text_len;       // L2_3 plus count of T

	modport source (
		input  new_read,
		output new_read_valid, batch_done, load_done, last, read_num, bases, len,
		       min_intv, primary, l2, text_len
	);

	modport sink (
		output new_read,
		input  new_read_valid, batch_done, load_done, last, read_num, bases, len,
		       min_intv, primary, l2, text_len
	);
endinterface

interface result_if
	import bwt_pkg::*;
	import read_pkg::*;
();
	logic      valid;     // held with data until ready
	logic      ready;     // low while the result FIFO is full
	logic      last;
	read_num_t read_num;
	read_len_t match_len;
	bwt_pos_t  k;
	bwt_pos_t  l;

	modport source (output valid, last, read_num, match_len, k, l, input ready);
	modport sink   (input valid, last, read_num, match_len, k, l, output ready);
endinterface

//--- read_buffer/read_ram.sv
module read_ram
	import bwt_pkg::*;
	import read_pkg::*;
#(
	parameter int BATCH_DEPTH = 64
) (
	input  logic       clk_32ui_i,
	input  logic       rst_n_i,
	input  logic       load_valid_i,
	input  load_word_t load_data_i,
	input  read_num_t  batch_size_i,
	read_if.source     rd_o
);

	localparam int AW      = $clog2(BATCH_DEPTH);
	localparam int POS_W   = $bits(bwt_pos_t);
	localparam int ENTRY_W = LW_MIN_INTV_LSB + $bits(read_len_t); // bases, len, min_intv

	typedef logic [AW-1:0] slot_t;

	logic [ENTRY_W-1:0] batch_mem [BATCH_DEPTH];
	logic [ENTRY_W-1:0] rd_entry;
	read_num_t          word_cnt;     // number of the next load word
	read_num_t          issue_cnt;    // next read to hand out
	read_num_t          batch_size_q;

	// ------------------------------------------------
	// batch loading
	// ------------------------------------------------
	always_ff @(posedge clk_32ui_i) begin
		if (!rst_n_i) begin
			word_cnt       <= '0;
			rd_o.load_done <= 1'b0;
		end else if (load_valid_i && !rd_o.load_done) begin
			word_cnt <= word_cnt + 1'b1;
			if (word_cnt != '0 && word_cnt == batch_size_q)
				rd_o.load_done <= 1'b1; // last read word just taken
		end
	end

	// word 0 holds the index constants, the rest are reads
	always_ff @(posedge clk_32ui_i) begin
		if (load_valid_i && !rd_o.load_done) begin
			if (word_cnt == '0) begin
				batch_size_q  <= batch_size_i;
				rd_o.primary  <= load_data_i[LW_PRIMARY_LSB +: POS_W];
				for (int i = 0; i < L2_COUNT; i++)
					rd_o.l2[i] <= load_data_i[LW_L2_LSB + POS_W*i +: POS_W];
				rd_o.text_len <= load_data_i[LW_L2_LSB + POS_W*(L2_COUNT-1) +: POS_W]
				               + load_data_i[LW_CNT_T_LSB +: POS_W];
			end else begin
				batch_mem[slot_t'(word_cnt - 1'b1)] <= load_data_i[ENTRY_W-1:0];
			end
		end
	end

	// ------------------------------------------------
	// read issue
	// ------------------------------------------------
	assign rd_entry = batch_mem[slot_t'(issue_cnt)];

	always_ff @(posedge clk_32ui_i) begin
		if (!rst_n_i) begin
			issue_cnt           <= '0;
			rd_o.new_read_valid <= 1'b0;
			rd_o.batch_done     <= 1'b0;
		end else begin
			rd_o.new_read_valid <= 1'b0;
			rd_o.batch_done     <= 1'b0;
			if (rd_o.new_read) begin
				if (issue_cnt == batch_size_q) begin
					rd_o.batch_done <= 1'b1;
				end else begin
					rd_o.new_read_valid <= 1'b1;
					issue_cnt           <= issue_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (rd_o.new_read) begin
			rd_o.read_num <= issue_cnt;
			rd_o.bases    <= rd_entry[LW_BASES_LSB +: $bits(read_bases_t)];
			rd_o.len      <= rd_entry[LW_LEN_LSB +: $bits(read_len_t)];
			rd_o.min_intv <= rd_entry[LW_MIN_INTV_LSB +: $bits(read_len_t)];
			rd_o.last     <= (issue_cnt + 1'b1 == batch_size_q);
		end
	end

	// the extender must wait for the whole batch
	a_read_after_load: assert property (@(posedge clk_32ui_i) disable iff (!rst_n_i)
		rd_o.new_read |-> rd_o.load_done)
		else $error("read_ram: new_read before load_done");

endmodule

//--- extend/occ_count.sv
module occ_count
	import bwt_pkg::*;
	import read_pkg::*;
(
	input  logic       clk_32ui_i,
	input  logic       rst_n_i,
	input  base_t      base_i,
	input  bwt_pos_t   pos_i,
	input  bwt_pos_t   primary_i,
	input  occ_cnt_t   cnt_i   [L2_COUNT],
	input  bwt_bases_t bases_i [L2_COUNT],
	output bwt_pos_t   occ_o
);

	bwt_pos_t                 adj_pos;
	logic [BLOCK_SHIFT-1:0]   offset;   // lookup offset inside the block
	logic [BLOCK_SHIFT:0]     hits;

	// skip the sentinel slot at primary
	assign adj_pos = (pos_i >= primary_i) ? pos_i - 1'b1 : pos_i;
	assign offset  = adj_pos[BLOCK_SHIFT-1:0];

	// count base_i among block offsets below offset
	always_comb begin
		base_t lane_base;
		hits = '0;
		for (int j = 0; j < BLOCK_BASES; j++) begin
			lane_base = bases_i[j / LANE_BASES][2*(j % LANE_BASES) +: 2];
			if (j < int'(offset) && lane_base == base_i)
				hits = hits + 1'b1;
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		occ_o <= bwt_pos_t'(cnt_i[base_i]) + bwt_pos_t'(hits);
	end

	// one block can add at most BLOCK_BASES
	a_occ_range: assert property (@(posedge clk_32ui_i) disable iff (!rst_n_i)
		occ_o <= bwt_pos_t'($past(cnt_i[base_i])) + BLOCK_BASES)
		else $error("occ_count: count beyond block range");

endmodule

//--- extend/extend_ctrl.sv
module extend_ctrl
	import bwt_pkg::*;
	import read_pkg::*;
(
	input  logic       clk_32ui_i,
	input  logic       rst_n_i,
	read_if.sink       rd_i,
	result_if.source   res_o,
	output logic       dram_valid_o,
	output dram_addr_t addr_k_o,
	output dram_addr_t addr_l_o,
	input  logic       dram_get_i,
	input  occ_cnt_t   cnt_a0_i, cnt_a1_i, cnt_a2_i, cnt_a3_i,
	input  bwt_bases_t cnt_b0_i, cnt_b1_i, cnt_b2_i, cnt_b3_i,
	input  occ_cnt_t   cntl_a0_i, cntl_a1_i, cntl_a2_i, cntl_a3_i,
	input  bwt_bases_t cntl_b0_i, cntl_b1_i, cntl_b2_i, cntl_b3_i
);

	typedef enum logic [2:0] {IDLE, FETCH, REQUEST, COUNT, UPDATE, RESULT, DONE} state_t;

	state_t      state;
	bwt_pos_t    k;           // last accepted interval
	bwt_pos_t    l;
	bwt_pos_t    new_k;
	bwt_pos_t    new_l;
	bwt_pos_t    occ_k;
	bwt_pos_t    occ_l;
	read_bases_t bases_q;
	read_len_t   idx;         // bases still to extend
	read_len_t   min_intv_q;
	read_len_t   match_len;
	read_num_t   read_num_q;
	logic        last_q;
	logic        new_read_q;
	logic        narrow;      // new interval below min_intv
	base_t       cur_base;
	occ_cnt_t    cnt_k [L2_COUNT];
	occ_cnt_t    cnt_l [L2_COUNT];
	bwt_bases_t  blk_k [L2_COUNT];
	bwt_bases_t  blk_l [L2_COUNT];

	assign cnt_k = '{cnt_a0_i, cnt_a1_i, cnt_a2_i, cnt_a3_i};
	assign blk_k = '{cnt_b0_i, cnt_b1_i, cnt_b2_i, cnt_b3_i};
	assign cnt_l = '{cntl_a0_i, cntl_a1_i, cntl_a2_i, cntl_a3_i};
	assign blk_l = '{cntl_b0_i, cntl_b1_i, cntl_b2_i, cntl_b3_i};

	assign cur_base = base_t'(bases_q >> {idx - 1'b1, 1'b0}); // base at idx-1
	assign narrow   = (new_l - new_k) < bwt_pos_t'(min_intv_q);

	// occ registered in the cycle of dram_get_i
	occ_count u_occ_k (
		.clk_32ui_i(clk_32ui_i), .rst_n_i(rst_n_i), .base_i(cur_base), .pos_i(k),
		.primary_i(rd_i.primary), .cnt_i(cnt_k), .bases_i(blk_k), .occ_o(occ_k)
	);

	occ_count u_occ_l (
		.clk_32ui_i(clk_32ui_i), .rst_n_i(rst_n_i), .base_i(cur_base), .pos_i(l),
		.primary_i(rd_i.primary), .cnt_i(cnt_l), .bases_i(blk_l), .occ_o(occ_l)
	);

	assign dram_valid_o = (state == REQUEST);
	assign addr_k_o     = dram_addr_t'(k >> BLOCK_SHIFT);
	assign addr_l_o     = dram_addr_t'(l >> BLOCK_SHIFT);
	assign rd_i.new_read = new_read_q;

	assign res_o.valid     = (state == RESULT);
	assign res_o.last      = last_q;
	assign res_o.read_num  = read_num_q;
	assign res_o.match_len = match_len;
	assign res_o.k         = k;
	assign res_o.l         = l;

	// ------------------------------------------------
	// per-read FSM
	// ------------------------------------------------
	always_ff @(posedge clk_32ui_i) begin
		if (!rst_n_i) begin
			state      <= IDLE;
			new_read_q <= 1'b0;
		end else begin
			new_read_q <= 1'b0;
			case (state)
				IDLE: if (rd_i.load_done) begin
					new_read_q <= 1'b1;
					state      <= FETCH;
				end
				FETCH: if (rd_i.batch_done)
					state <= DONE;
				else if (rd_i.new_read_valid)
					state <= (rd_i.len == '0) ? RESULT : REQUEST;
				REQUEST: if (dram_get_i)
					state <= COUNT;
				COUNT: state <= UPDATE;
				UPDATE: state <= (narrow || idx == read_len_t'(1)) ? RESULT : REQUEST;
				RESULT: if (res_o.ready) begin
					new_read_q <= 1'b1; // ask for the next read right away
					state      <= FETCH;
				end
				default: state <= DONE;
			endcase
		end
	end

	// interval datapath
	always_ff @(posedge clk_32ui_i) begin
		case (state)
			FETCH: if (rd_i.new_read_valid) begin
				read_num_q <= rd_i.read_num;
				bases_q    <= rd_i.bases;
				idx        <= rd_i.len;
				min_intv_q <= rd_i.min_intv;
				last_q     <= rd_i.last;
				match_len  <= '0;
				k          <= '0;
				l          <= rd_i.text_len; // whole text
			end
			COUNT: begin
				new_k <= rd_i.l2[cur_base] + occ_k;
				new_l <= rd_i.l2[cur_base] + occ_l;
			end
			UPDATE: if (!narrow) begin
				k         <= new_k;
				l         <= new_l;
				match_len <= match_len + 1'b1;
				idx       <= idx - 1'b1;
			end
			default: ;
		endcase
	end

	a_addr_hold: assert property (@(posedge clk_32ui_i) disable iff (!rst_n_i)
		dram_valid_o && !dram_get_i |=> dram_valid_o && $stable(addr_k_o) && $stable(addr_l_o))
		else $error("extend_ctrl: DRAM request changed before dram_get_i");

endmodule

//--- hdl/result_out.sv
module result_out
	import bwt_pkg::*;
	import read_pkg::*;
#(
	parameter int RESULT_DEPTH = 4 // power of two
) (
	input  logic         clk_32ui_i,
	input  logic         rst_n_i,
	result_if.sink       res_i,
	output logic         output_request_o,
	input  logic         output_permit_i,
	output result_word_t output_data_o,
	output logic         output_valid_o,
	output logic         output_finish_o
);

	localparam int PW = $clog2(RESULT_DEPTH);

	typedef enum logic {WAIT, SEND} state_t;

	state_t        state;
	read_num_t     fifo_num  [RESULT_DEPTH];
	read_len_t     fifo_len  [RESULT_DEPTH];
	bwt_pos_t      fifo_k    [RESULT_DEPTH];
	bwt_pos_t      fifo_l    [RESULT_DEPTH];
	logic          fifo_last [RESULT_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [PW:0]   count;
	logic          push;
	logic          pop;
	logic          finish_q;   // word in flight is the last one
	result_word_t  head_word;

	assign res_i.ready      = (count != (PW+1)'(RESULT_DEPTH));
	assign push             = res_i.valid && res_i.ready;
	assign output_request_o = (state == WAIT) && (count != '0);
	assign pop              = output_request_o && output_permit_i;

	assign output_valid_o  = (state == SEND);
	assign output_finish_o = (state == SEND) && finish_q;

	// head of the FIFO in result word form
	always_comb begin
		head_word = '0;
		head_word[RW_NUM_LSB +: READ_NUM_WIDTH]     = fifo_num[rd_ptr];
		head_word[RW_LEN_LSB +: $bits(read_len_t)]  = fifo_len[rd_ptr];
		head_word[RW_K_LSB +: $bits(bwt_pos_t)]     = fifo_k[rd_ptr];
		head_word[RW_L_LSB +: $bits(bwt_pos_t)]     = fifo_l[rd_ptr];
	end

	// ------------------------------------------------
	// FIFO pointers and request/permit FSM
	// ------------------------------------------------
	always_ff @(posedge clk_32ui_i) begin
		if (!rst_n_i) begin
			state  <= WAIT;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + push - pop;
			state <= pop ? SEND : WAIT; // SEND lasts one cycle
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (push) begin
			fifo_num[wr_ptr]  <= res_i.read_num;
			fifo_len[wr_ptr]  <= res_i.match_len;
			fifo_k[wr_ptr]    <= res_i.k;
			fifo_l[wr_ptr]    <= res_i.l;
			fifo_last[wr_ptr] <= res_i.last;
		end
		if (pop) begin
			output_data_o <= head_word;
			finish_q      <= fifo_last[rd_ptr];
		end
	end

	a_valid_after_permit: assert property (@(posedge clk_32ui_i) disable iff (!rst_n_i)
		output_valid_o |-> $past(output_permit_i && output_request_o))
		else $error("result_out: output_valid_o without a granted request");

endmodule

//--- hdl/smem_top.sv
module smem_top
	import bwt_pkg::*;
	import read_pkg::*;
#(
	parameter int BATCH_DEPTH  = 64,
	parameter int RESULT_DEPTH = 4
) (
	input  logic         clk_32ui_i,
	input  logic         rst_n_i,
	input  logic         load_valid_i,
	input  load_word_t   load_data_i,
	input  read_num_t    batch_size_i,
	output logic         dram_valid_o,
	output dram_addr_t   addr_k_o,
	output dram_addr_t   addr_l_o,
	input  logic         dram_get_i,
	input  occ_cnt_t     cnt_a0_i, cnt_a1_i, cnt_a2_i, cnt_a3_i,
	input  bwt_bases_t   cnt_b0_i, cnt_b1_i, cnt_b2_i, cnt_b3_i,
	input  occ_cnt_t     cntl_a0_i, cntl_a1_i, cntl_a2_i, cntl_a3_i,
	input  bwt_bases_t   cntl_b0_i, cntl_b1_i, cntl_b2_i, cntl_b3_i,
	output logic         output_request_o,
	input  logic         output_permit_i,
	output result_word_t output_data_o,
	output logic         output_valid_o,
	output logic         output_finish_o
);

	read_if   rd_bus ();
	result_if res_bus ();

	read_ram #(.BATCH_DEPTH(BATCH_DEPTH)) u_read_ram (
		.clk_32ui_i(clk_32ui_i), .rst_n_i(rst_n_i), .load_valid_i(load_valid_i),
		.load_data_i(load_data_i), .batch_size_i(batch_size_i), .rd_o(rd_bus)
	);

	// single requester on the DRAM port
	extend_ctrl u_extend_ctrl (
		.clk_32ui_i(clk_32ui_i), .rst_n_i(rst_n_i), .rd_i(rd_bus), .res_o(res_bus),
		.dram_valid_o(dram_valid_o), .addr_k_o(addr_k_o), .addr_l_o(addr_l_o),
		.dram_get_i(dram_get_i),
		.cnt_a0_i(cnt_a0_i), .cnt_a1_i(cnt_a1_i), .cnt_a2_i(cnt_a2_i), .cnt_a3_i(cnt_a3_i),
		.cnt_b0_i(cnt_b0_i), .cnt_b1_i(cnt_b1_i), .cnt_b2_i(cnt_b2_i), .cnt_b3_i(cnt_b3_i),
		.cntl_a0_i(cntl_a0_i), .cntl_a1_i(cntl_a1_i), .cntl_a2_i(cntl_a2_i),
		.cntl_a3_i(cntl_a3_i),
		.cntl_b0_i(cntl_b0_i), .cntl_b1_i(cntl_b1_i), .cntl_b2_i(cntl_b2_i),
		.cntl_b3_i(cntl_b3_i)
	);

	result_out #(.RESULT_DEPTH(RESULT_DEPTH)) u_result_out (
		.clk_32ui_i(clk_32ui_i), .rst_n_i(rst_n_i), .res_i(res_bus),
		.output_request_o(output_request_o), .output_permit_i(output_permit_i),
		.output_data_o(output_data_o), .output_valid_o(output_valid_o),
		.output_finish_o(output_finish_o)
	);

endmodule

//--- tests/tb_bwt_model.svh
`ifndef TB_BWT_MODEL_SVH
`define TB_BWT_MODEL_SVH

// ------------------------------------------------
// reference index for tb_smem
// ------------------------------------------------
localparam int TEXT_LEN         = 1024;
localparam int NUM_BLOCKS       = TEXT_LEN / BLOCK_BASES + 1; // last block sits past the end
localparam int NUM_READS        = 12;
localparam int SEED             = 32'h3ac7a270;
localparam int DRAM_IDLE_LIMIT  = 3000;  // cycles without a DRAM request
localparam int PERMIT_IDLE_LIMIT = 3000;
localparam int RESULT_LIMIT     = 40000;

base_t      bwt_base [NUM_BLOCKS*BLOCK_BASES]; // random stand-in BWT, tail is padding
occ_cnt_t   blk_cnt  [NUM_BLOCKS][L2_COUNT];   // base counts before each block
bwt_pos_t   primary;
bwt_pos_t   l2 [L2_COUNT];
bwt_pos_t   text_len;
load_word_t read_words [NUM_READS];
read_len_t  exp_len [1 << READ_NUM_WIDTH];
bwt_pos_t   exp_k   [1 << READ_NUM_WIDTH];
bwt_pos_t   exp_l   [1 << READ_NUM_WIDTH];
dram_addr_t exp_addr_k [$]; // one entry per extension step, all reads in order
dram_addr_t exp_addr_l [$];

function automatic void build_index();
	occ_cnt_t tally [L2_COUNT];
	tally = '{default: '0};
	for (int p = 0; p < NUM_BLOCKS*BLOCK_BASES; p++) begin
		if (p % BLOCK_BASES == 0)
			blk_cnt[p / BLOCK_BASES] = tally;
		bwt_base[p] = base_t'($urandom_range(3));
		if (p < TEXT_LEN)
			tally[bwt_base[p]]++;
	end
	l2[0] = '0;
	for (int c = 1; c < L2_COUNT; c++)
		l2[c] = l2[c-1] + bwt_pos_t'(tally[c-1]);
	text_len = l2[L2_COUNT-1] + bwt_pos_t'(tally[L2_COUNT-1]);
	primary  = bwt_pos_t'($urandom_range(1, TEXT_LEN - 1));
endfunction

function automatic int block_index(input dram_addr_t addr);
	return (addr < NUM_BLOCKS) ? int'(addr) : NUM_BLOCKS - 1;
endfunction

// lane w holds block offsets 32w .. 32w+31, two bits each
function automatic bwt_bases_t block_lane(input dram_addr_t addr, input int w);
	bwt_bases_t lane;
	int         b;
	b = block_index(addr);
	for (int j = 0; j < LANE_BASES; j++)
		lane[2*j +: 2] = bwt_base[b*BLOCK_BASES + w*LANE_BASES + j];
	return lane;
endfunction

function automatic bwt_pos_t model_occ(input base_t c, input bwt_pos_t pos);
	bwt_pos_t adj;
	bwt_pos_t n;
	int       b;
	adj = (pos >= primary) ? pos - 1 : pos; // sentinel slot
	b   = block_index(dram_addr_t'(pos / BLOCK_BASES));
	n   = bwt_pos_t'(blk_cnt[b][c]);
	for (int j = 0; j < int'(adj % BLOCK_BASES); j++)
		if (bwt_base[b*BLOCK_BASES + j] == c)
			n++;
	return n;
endfunction

// backward extension from the last base, stops on a narrow interval
function automatic void model_extend(input int r);
	bwt_pos_t    k;
	bwt_pos_t    l;
	bwt_pos_t    nk;
	bwt_pos_t    nl;
	base_t       c;
	read_len_t   match;
	read_bases_t bases;
	int          len;
	bwt_pos_t    min_intv;
	bases    = read_words[r][LW_BASES_LSB +: $bits(read_bases_t)];
	len      = int'(read_words[r][LW_LEN_LSB +: $bits(read_len_t)]);
	min_intv = bwt_pos_t'(read_words[r][LW_MIN_INTV_LSB +: $bits(read_len_t)]);
	k        = '0;
	l        = text_len;
	match    = '0;
	for (int idx = len; idx > 0; idx--) begin
		exp_addr_k.push_back(dram_addr_t'(k / BLOCK_BASES));
		exp_addr_l.push_back(dram_addr_t'(l / BLOCK_BASES));
		c  = bases[2*(idx-1) +: 2];
		nk = l2[c] + model_occ(c, k);
		nl = l2[c] + model_occ(c, l);
		if (nl - nk < min_intv)
			break;
		k = nk;
		l = nl;
		match++;
	end
	exp_len[r] = match;
	exp_k[r]   = k;
	exp_l[r]   = l;
endfunction

`endif

//--- tests/tb_smem.sv
module tb_smem
	import bwt_pkg::*;
	import read_pkg::*;
();

	logic         clk = 1'b0;
	logic         rst_n;
	logic         load_valid;
	load_word_t   load_data;
	read_num_t    batch_size;
	logic         dram_valid;
	logic         dram_get;
	dram_addr_t   addr_k;
	dram_addr_t   addr_l;
	occ_cnt_t     cnt_a  [L2_COUNT];
	bwt_bases_t   cnt_b  [L2_COUNT];
	occ_cnt_t     cntl_a [L2_COUNT];
	bwt_bases_t   cntl_b [L2_COUNT];
	logic         out_request;
	logic         out_permit;
	logic         out_valid;
	logic         out_finish;
	result_word_t out_data;
	read_num_t    out_num;
	dram_addr_t   cur_addr_k = '0; // model step of the pending request
	dram_addr_t   cur_addr_l = '0;
	logic         in_reset_q = 1'b0;
	int           errors = 0;
	int           results_seen = 0;
	int           finish_seen = 0;

	`include "tb_bwt_model.svh"

	task automatic note_error(input string msg);
		errors++;
		$display("ERROR %0t: %s", $time, msg);
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timeout waiting for %s, errors so far: %0d", what, errors);
		$display("RESULT: FAIL");
		$finish;
	endtask

	// even reads copy stored bases, odd ones are random
	function automatic void make_reads();
		read_bases_t b;
		int          len;
		int          start;
		read_len_t   min_intv;
		for (int r = 0; r < NUM_READS; r++) begin
			len      = (r == 5) ? 0 : $urandom_range(8, 40);
			start    = $urandom_range(TEXT_LEN - len);
			min_intv = (r % 4 == 0) ? '0 : read_len_t'($urandom_range(1, 40));
			b        = '0;
			for (int i = 0; i < len; i++)
				b[2*i +: 2] = (r % 2 == 0) ? bwt_base[start + i] : base_t'($urandom_range(3));
			read_words[r] = '0;
			read_words[r][LW_BASES_LSB +: $bits(read_bases_t)]  = b;
			read_words[r][LW_LEN_LSB +: $bits(read_len_t)]      = read_len_t'(len);
			read_words[r][LW_MIN_INTV_LSB +: $bits(read_len_t)] = min_intv;
		end
	endfunction

	task automatic load_batch();
		load_word_t w;
		w = '0;
		w[LW_PRIMARY_LSB +: $bits(bwt_pos_t)] = primary;
		for (int c = 0; c < L2_COUNT; c++)
			w[LW_L2_LSB + $bits(bwt_pos_t)*c +: $bits(bwt_pos_t)] = l2[c];
		w[LW_CNT_T_LSB +: $bits(bwt_pos_t)] = text_len - l2[L2_COUNT-1];
		batch_size = read_num_t'(NUM_READS);
		load_valid = 1'b1;
		load_data  = w;
		for (int r = 0; r < NUM_READS; r++) begin
			@(negedge clk);
			load_data = read_words[r];
		end
		@(negedge clk);
		load_valid = 1'b0;
	endtask

	smem_top dut_i (
		.clk_32ui_i(clk), .rst_n_i(rst_n), .load_valid_i(load_valid),
		.load_data_i(load_data), .batch_size_i(batch_size),
		.dram_valid_o(dram_valid), .addr_k_o(addr_k), .addr_l_o(addr_l), .dram_get_i(dram_get),
		.cnt_a0_i(cnt_a[0]), .cnt_a1_i(cnt_a[1]), .cnt_a2_i(cnt_a[2]), .cnt_a3_i(cnt_a[3]),
		.cnt_b0_i(cnt_b[0]), .cnt_b1_i(cnt_b[1]), .cnt_b2_i(cnt_b[2]), .cnt_b3_i(cnt_b[3]),
		.cntl_a0_i(cntl_a[0]), .cntl_a1_i(cntl_a[1]), .cntl_a2_i(cntl_a[2]),
		.cntl_a3_i(cntl_a[3]),
		.cntl_b0_i(cntl_b[0]), .cntl_b1_i(cntl_b[1]), .cntl_b2_i(cntl_b[2]),
		.cntl_b3_i(cntl_b[3]),
		.output_request_o(out_request), .output_permit_i(out_permit),
		.output_data_o(out_data), .output_valid_o(out_valid), .output_finish_o(out_finish)
	);

	always #20 clk = ~clk;

	assign out_num = out_data[RW_NUM_LSB +: READ_NUM_WIDTH];

	always @(posedge clk) begin
		in_reset_q <= !rst_n;
		if (out_valid)
			results_seen <= results_seen + 1;
		if (out_finish)
			finish_seen <= finish_seen + 1;
	end

	// ------------------------------------------------
	// checks
	// ------------------------------------------------
	a_reset_quiet: assert property (@(posedge clk)
		in_reset_q |-> !dram_valid && !out_request && !out_valid && !out_finish)
		else note_error("DUT outputs active during reset");

	a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		dram_valid && !dram_get |=> $stable(addr_k) && $stable(addr_l))
		else note_error("DRAM address changed while the request was pending");

	a_addr_model: assert property (@(posedge clk) disable iff (!rst_n)
		dram_valid && dram_get |-> addr_k == cur_addr_k && addr_l == cur_addr_l)
		else note_error($sformatf("DRAM blocks %0d/%0d, model wants %0d/%0d",
			addr_k, addr_l, cur_addr_k, cur_addr_l));

	a_result_value: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> out_data[RW_LEN_LSB +: $bits(read_len_t)] == exp_len[out_num]
			&& out_data[RW_K_LSB +: $bits(bwt_pos_t)] == exp_k[out_num]
			&& out_data[RW_L_LSB +: $bits(bwt_pos_t)] == exp_l[out_num]
			&& out_data[63:16] == '0 && out_data[511:192] == '0)
		else note_error($sformatf("read %0d result len %0d k %0d l %0d differs from model",
			out_num, out_data[15:8], out_data[127:64], out_data[191:128]));

	a_result_order: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> int'(out_num) == results_seen)
		else note_error($sformatf("read %0d out of order, expected %0d", out_num, results_seen));

	a_finish_last: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && int'(out_num) == NUM_READS - 1) == out_finish)
		else note_error("output_finish_o not aligned with the last result");

	// exactly one cycle after a granted request
	a_valid_after_permit: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == $past(out_permit && out_request))
		else note_error("output_valid_o does not follow the permit");

	// ------------------------------------------------
	// responders
	// ------------------------------------------------
	initial begin : dram_responder
		int n;
		forever begin
			n = 0;
			while (dram_valid !== 1'b1 && n < DRAM_IDLE_LIMIT) begin
				@(negedge clk);
				n++;
			end
			if (dram_valid !== 1'b1) begin
				abort_on_timeout("a DRAM request");
			end else begin
				if (exp_addr_k.size() == 0) begin
					note_error("DRAM request beyond the model's extension steps");
					cur_addr_k = '1;
					cur_addr_l = '1;
				end else begin
					cur_addr_k = exp_addr_k.pop_front();
					cur_addr_l = exp_addr_l.pop_front();
				end
				repeat ($urandom_range(5)) @(negedge clk);
				for (int i = 0; i < L2_COUNT; i++) begin
					cnt_a[i]  = blk_cnt[block_index(addr_k)][i];
					cnt_b[i]  = block_lane(addr_k, i);
					cntl_a[i] = blk_cnt[block_index(addr_l)][i];
					cntl_b[i] = block_lane(addr_l, i);
				end
				dram_get = 1'b1;
				@(negedge clk);
				dram_get = 1'b0;
			end
		end
	end

	initial begin : permit_responder
		int n;
		int delay;
		forever begin
			n = 0;
			while (out_request !== 1'b1 && n < PERMIT_IDLE_LIMIT) begin
				@(negedge clk);
				n++;
			end
			if (out_request !== 1'b1) begin
				abort_on_timeout("an output request");
			end else begin
				// long delays early so the result FIFO fills up
				delay = (results_seen < NUM_READS/2) ? $urandom_range(150, 250)
				                                     : $urandom_range(3);
				repeat (delay) @(negedge clk);
				out_permit = 1'b1;
				@(negedge clk);
				out_permit = 1'b0;
			end
		end
	end

	// ------------------------------------------------
	// main sequence
	// ------------------------------------------------
	initial begin : main_seq
		int n;
		void'($urandom(SEED));
		rst_n      = 1'b0;
		load_valid = 1'b0;
		load_data  = '0;
		batch_size = '0;
		dram_get   = 1'b0;
		out_permit = 1'b0;
		cnt_a      = '{default: '0};
		cnt_b      = '{default: '0};
		cntl_a     = '{default: '0};
		cntl_b     = '{default: '0};
		build_index();
		make_reads();
		for (int r = 0; r < NUM_READS; r++)
			model_extend(r);
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		load_batch();
		n = 0;
		while (results_seen < NUM_READS && n < RESULT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (results_seen < NUM_READS) begin
			abort_on_timeout("all results");
		end else begin
			repeat (8) @(negedge clk); // a duplicate word would land here
			assert (finish_seen == 1)
				else note_error("output_finish_o did not pulse exactly once");
			assert (exp_addr_k.size() == 0)
				else note_error("fewer DRAM requests than the model's extension steps");
			$display("errors: %0d, results: %0d of %0d, finish pulses: %0d",
				errors, results_seen, NUM_READS, finish_seen);
			if (errors == 0)
				$display("RESULT: PASS");
			else
				$display("RESULT: FAIL");
			$finish;
		end
	end

endmodule

//--- flist.f
+incdir+tests
common/bwt_pkg.sv
common/read_pkg.sv
common/smem_ifs.sv
read_buffer/read_ram.sv
extend/occ_count.sv
extend/extend_ctrl.sv
hdl/result_out.sv
hdl/smem_top.sv
tests/tb_smem.sv

//--- Makefile
# Verilator flow for the SMEM extender testbench

VERILATOR  ?= verilator
TB_TOP     ?= tb_smem
RTL_TOP    ?= smem_top
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall

SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)
SOURCES := $(shell grep -v '^+' $(FLIST)) $(wildcard tests/*.svh)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
